// ==== conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// filter lanes computed side by side
`define CONV_LANES      4
// pixels per 3x3 window
`define CONV_TAPS       9

// Q16.16 pixels, weights, bias and results
`define DATA_WIDTH      32
`define FRAC_WIDTH      16
`define ACC_WIDTH       48

`define COL_WIDTH       6
`define CHAN_WIDTH      8
`define FMAP_DEPTH      64

// slots 0..8 hold weights, slot 9 the bias
`define TAP_SEL_WIDTH   4

`endif

// ==== conv_pkg.sv ====
`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

    typedef logic signed [`DATA_WIDTH-1:0] data_t;
    typedef logic signed [`ACC_WIDTH-1:0]  acc_t;
    typedef logic [`COL_WIDTH-1:0]         col_t;
    typedef logic [`CHAN_WIDTH-1:0]        chan_t;
    typedef logic [$clog2(`CONV_LANES)-1:0] lane_t;

    typedef data_t [`CONV_TAPS-1:0]  window_t;
    typedef acc_t  [`CONV_LANES-1:0] lane_sums_t;
    typedef data_t [`CONV_LANES-1:0] lane_data_t;

    typedef struct packed {
        window_t [`CONV_LANES-1:0] weights;
        lane_data_t                bias;
    } weight_set_t;

    // position of a window inside the frame
    typedef struct packed {
        col_t col;
        logic first_chan;
        logic last_chan;
        logic last_in_frame;
    } win_tag_t;

    typedef struct packed {
        logic                      valid;
        lane_t                     lane;
        logic [`TAP_SEL_WIDTH-1:0] slot;
        data_t                     value;
    } weight_load_t;

    typedef struct packed {
        chan_t num_chans;
        col_t  num_cols;
    } frame_cfg_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_CAPTURE,
        RX_WAIT_REQ_LOW
    } rx_state_t;

endpackage

`default_nettype wire

// ==== window_receiver.sv ====
`timescale 1ns/100ps
`default_nettype none

module window_receiver (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire logic                 i_start,
    input  wire conv_pkg::frame_cfg_t i_cfg,
    input  wire logic                 i_win_req,
    input  wire conv_pkg::window_t    i_win_data,
    output logic                      o_win_ack,
    output logic                      o_issue,
    output conv_pkg::window_t         o_window,
    output conv_pkg::win_tag_t        o_tag
);

    conv_pkg::rx_state_t state;
    conv_pkg::chan_t     chan_cnt;
    conv_pkg::col_t      col_cnt;
    logic                last_chan;
    logic                last_col;
    logic                capture;

    assign last_chan = (chan_cnt == i_cfg.num_chans - conv_pkg::chan_t'(1));
    assign last_col  = (col_cnt == i_cfg.num_cols - conv_pkg::col_t'(1));
    assign capture   = (state == conv_pkg::RX_CAPTURE) && i_win_req;
    assign o_win_ack = (state == conv_pkg::RX_WAIT_REQ_LOW);

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state    <= conv_pkg::RX_IDLE;
            chan_cnt <= '0;
            col_cnt  <= '0;
            o_issue  <= 1'b0;
        end else begin
            o_issue <= capture;
            case (state)
                conv_pkg::RX_IDLE: begin
                    if (i_start) begin
                        chan_cnt <= '0;
                        col_cnt  <= '0;
                        state    <= conv_pkg::RX_CAPTURE;
                    end
                end
                conv_pkg::RX_CAPTURE: begin
                    if (i_win_req) begin
                        state <= conv_pkg::RX_WAIT_REQ_LOW;
                        // channels run fastest, then columns
                        if (last_chan) begin
                            chan_cnt <= '0;
                            col_cnt  <= col_cnt + conv_pkg::col_t'(1);
                        end else begin
                            chan_cnt <= chan_cnt + conv_pkg::chan_t'(1);
                        end
                    end
                end
                conv_pkg::RX_WAIT_REQ_LOW: begin
                    if (!i_win_req) begin
                        state <= o_tag.last_in_frame ? conv_pkg::RX_IDLE : conv_pkg::RX_CAPTURE;
                    end
                end
                default: state <= conv_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (capture) begin
            o_window            <= i_win_data;
            o_tag.col           <= col_cnt;
            o_tag.first_chan    <= (chan_cnt == '0);
            o_tag.last_chan     <= last_chan;
            o_tag.last_in_frame <= last_chan && last_col;
        end
    end

    ack_needs_req: assert property (@(posedge i_clock) disable iff (!i_reset)
        $rose(o_win_ack) |-> $past(i_win_req))
        else $error("ack rose without req");

endmodule

`default_nettype wire

// ==== weight_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module weight_bank (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire conv_pkg::weight_load_t i_weight_load,
    output conv_pkg::weight_set_t       o_weights
);

    logic is_bias;
    logic is_weight;

    // slots past the bias slot are dropped
    assign is_bias   = (i_weight_load.slot == `CONV_TAPS);
    assign is_weight = (i_weight_load.slot < `CONV_TAPS);

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            o_weights <= '0;
        end else if (i_weight_load.valid) begin
            if (is_bias) begin
                o_weights.bias[i_weight_load.lane] <= i_weight_load.value;
            end else if (is_weight) begin
                o_weights.weights[i_weight_load.lane][i_weight_load.slot] <= i_weight_load.value;
            end
        end
    end

    slot_in_range: assert property (@(posedge i_clock) disable iff (!i_reset)
        i_weight_load.valid |-> (i_weight_load.slot <= `CONV_TAPS))
        else $error("weight load slot %0d out of range", i_weight_load.slot);

endmodule

`default_nettype wire

// ==== mac_array.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module mac_array (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire logic                  i_issue,
    input  wire conv_pkg::window_t     i_window,
    input  wire conv_pkg::win_tag_t    i_tag,
    input  wire conv_pkg::weight_set_t i_weights,
    output logic                       o_sum_valid,
    output conv_pkg::lane_sums_t       o_sums,
    output conv_pkg::win_tag_t         o_tag
);

    conv_pkg::acc_t       prod_next [`CONV_LANES][`CONV_TAPS];
    conv_pkg::acc_t       prod_q    [`CONV_LANES][`CONV_TAPS];
    conv_pkg::lane_sums_t sum_next;
    conv_pkg::win_tag_t   tag_q;
    logic                 valid_q;

    // stage 1 products, rescaled back to Q16.16
    always_comb begin
        logic signed [2*`DATA_WIDTH-1:0] product;
        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                product = $signed(i_window[t]) * $signed(i_weights.weights[l][t]);
                prod_next[l][t] = conv_pkg::acc_t'(product >>> `FRAC_WIDTH);
            end
        end
    end

    // stage 2 nine-term adder per lane
    always_comb begin
        for (int l = 0; l < `CONV_LANES; l++) begin
            sum_next[l] = '0;
            for (int t = 0; t < `CONV_TAPS; t++) begin
                sum_next[l] = sum_next[l] + prod_q[l][t];
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            valid_q     <= 1'b0;
            o_sum_valid <= 1'b0;
        end else begin
            valid_q     <= i_issue;
            o_sum_valid <= valid_q;
        end
    end

    // data and tag follow the valid bits with no stall
    always_ff @(posedge i_clock) begin
        prod_q <= prod_next;
        tag_q  <= i_tag;
        o_sums <= sum_next;
        o_tag  <= tag_q;
    end

endmodule

`default_nettype wire

// ==== channel_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module channel_accumulator (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire logic                  i_sum_valid,
    input  wire conv_pkg::lane_sums_t  i_sums,
    input  wire conv_pkg::win_tag_t    i_tag,
    input  wire conv_pkg::weight_set_t i_weights,
    output logic                       o_wr_en,
    output conv_pkg::col_t             o_wr_col,
    output conv_pkg::lane_data_t       o_wr_data,
    output logic                       o_done
);

    localparam conv_pkg::data_t DATA_MAX = {1'b0, {(`DATA_WIDTH-1){1'b1}}};
    localparam conv_pkg::data_t DATA_MIN = {1'b1, {(`DATA_WIDTH-1){1'b0}}};

    conv_pkg::lane_sums_t acc_q;
    conv_pkg::lane_sums_t total_next;
    conv_pkg::lane_data_t result_next;

    // clip to 32 bits, then ReLU
    function automatic conv_pkg::data_t sat_relu(input conv_pkg::acc_t value);
        conv_pkg::data_t clipped;
        if (value > conv_pkg::acc_t'(DATA_MAX)) begin
            clipped = DATA_MAX;
        end else if (value < conv_pkg::acc_t'(DATA_MIN)) begin
            clipped = DATA_MIN;
        end else begin
            clipped = value[`DATA_WIDTH-1:0];
        end
        return (clipped < 0) ? '0 : clipped;
    endfunction

    always_comb begin
        for (int l = 0; l < `CONV_LANES; l++) begin
            total_next[l]  = i_tag.first_chan ? i_sums[l] : acc_q[l] + i_sums[l];
            result_next[l] = sat_relu(total_next[l]
                                      + conv_pkg::acc_t'($signed(i_weights.bias[l])));
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            o_wr_en <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_wr_en <= i_sum_valid && i_tag.last_chan;
            o_done  <= i_sum_valid && i_tag.last_in_frame;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_sum_valid) begin
            acc_q <= total_next;
        end
        if (i_sum_valid && i_tag.last_chan) begin
            o_wr_col  <= i_tag.col;
            o_wr_data <= result_next;
        end
    end

    // every write lands inside the feature memory
    wr_col_in_range: assert property (@(posedge i_clock) disable iff (!i_reset)
        o_wr_en |-> (o_wr_col < `FMAP_DEPTH))
        else $error("write column %0d out of range", o_wr_col);

endmodule

`default_nettype wire

// ==== feature_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module feature_memory (
    input  wire logic                 i_clock,
    input  wire logic                 i_wr_en,
    input  wire conv_pkg::col_t       i_wr_col,
    input  wire conv_pkg::lane_data_t i_wr_data,
    input  wire conv_pkg::col_t       i_rd_addr,
    output conv_pkg::lane_data_t      o_rd_data
);

    // one entry per output column, all four lanes side by side
    conv_pkg::lane_data_t mem [`FMAP_DEPTH];

    always_ff @(posedge i_clock) begin
        if (i_wr_en) begin
            mem[i_wr_col] <= i_wr_data;
        end
    end

    // read port returns old data on a same-cycle write
    always_ff @(posedge i_clock) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

// ==== conv_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_top (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_start,
    input  wire conv_pkg::frame_cfg_t   i_cfg,
    input  wire logic                   i_win_req,
    input  wire conv_pkg::window_t      i_win_data,
    output logic                        o_win_ack,
    input  wire conv_pkg::weight_load_t i_weight_load,
    input  wire conv_pkg::col_t         i_rd_addr,
    output conv_pkg::lane_data_t        o_rd_data,
    output logic                        o_done
);

    logic                  issue;
    conv_pkg::window_t     window;
    conv_pkg::win_tag_t    rx_tag;
    conv_pkg::weight_set_t weights;
    logic                  sum_valid;
    conv_pkg::lane_sums_t  sums;
    conv_pkg::win_tag_t    mac_tag;
    logic                  wr_en;
    conv_pkg::col_t        wr_col;
    conv_pkg::lane_data_t  wr_data;

    // input side
    window_receiver u_window_receiver (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_start    (i_start),
        .i_cfg      (i_cfg),
        .i_win_req  (i_win_req),
        .i_win_data (i_win_data),
        .o_win_ack  (o_win_ack),
        .o_issue    (issue),
        .o_window   (window),
        .o_tag      (rx_tag)
    );

    weight_bank u_weight_bank (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_weight_load (i_weight_load),
        .o_weights     (weights)
    );

    mac_array u_mac_array (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_issue     (issue),
        .i_window    (window),
        .i_tag       (rx_tag),
        .i_weights   (weights),
        .o_sum_valid (sum_valid),
        .o_sums      (sums),
        .o_tag       (mac_tag)
    );

    // output side
    channel_accumulator u_channel_accumulator (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_sum_valid (sum_valid),
        .i_sums      (sums),
        .i_tag       (mac_tag),
        .i_weights   (weights),
        .o_wr_en     (wr_en),
        .o_wr_col    (wr_col),
        .o_wr_data   (wr_data),
        .o_done      (o_done)
    );

    feature_memory u_feature_memory (
        .i_clock   (i_clock),
        .i_wr_en   (wr_en),
        .i_wr_col  (wr_col),
        .i_wr_data (wr_data),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

endmodule

`default_nettype wire

// ==== tb_conv_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module tb_conv_top;

    localparam int TIMEOUT = 200;
    localparam conv_pkg::data_t ONE = 32'sh0001_0000;

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   start;
    conv_pkg::frame_cfg_t   cfg;
    logic                   win_req;
    conv_pkg::window_t      win_data;
    logic                   win_ack;
    conv_pkg::weight_load_t weight_load;
    conv_pkg::col_t         rd_addr;
    conv_pkg::lane_data_t   rd_data;
    logic                   done;

    // host side bookkeeping
    logic                 last_win;
    logic                 seen_req;
    logic                 rd_chk;
    conv_pkg::lane_data_t rd_exp;
    int                   errors = 0;
    int                   done_count = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    int                   test_base;

    conv_pkg::data_t pix [3][8][9];
    conv_pkg::data_t wt [4][9];
    conv_pkg::data_t bias [4];

    conv_top dut0 (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_start       (start),
        .i_cfg         (cfg),
        .i_win_req     (win_req),
        .i_win_data    (win_data),
        .o_win_ack     (win_ack),
        .i_weight_load (weight_load),
        .i_rd_addr     (rd_addr),
        .o_rd_data     (rd_data),
        .o_done        (done)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        if (reset && done) begin
            done_count <= done_count + 1;
        end
    end

    idle_after_reset: assert property (@(posedge clock) disable iff (!reset)
        !seen_req |-> (!win_ack && !done))
        else begin
            errors++;
            $display("** Error: win_ack = %h, done = %h, expected 0 before first req",
                     win_ack, done);
        end

    ack_rise_with_req: assert property (@(posedge clock) disable iff (!reset)
        $rose(win_ack) |-> $past(win_req))
        else begin
            errors++;
            $display("ack rose while req was low");
        end

    ack_fall_after_req: assert property (@(posedge clock) disable iff (!reset)
        $fell(win_ack) |-> !$past(win_req))
        else begin
            errors++;
            $display("ack fell while req was still high");
        end

    ack_holds: assert property (@(posedge clock) disable iff (!reset)
        (win_ack && win_req) |=> win_ack)
        else begin
            errors++;
            $display("ack dropped before req went low");
        end

    done_after_last: assert property (@(posedge clock) disable iff (!reset)
        ($rose(win_ack) && last_win) |-> ##3 done)
        else begin
            errors++;
            $display("done missing 3 cycles after the last ack rise");
        end

    done_not_early: assert property (@(posedge clock) disable iff (!reset)
        done |-> ($past(win_ack && last_win, 3) && !$past(win_ack, 4)))
        else begin
            errors++;
            $display("done pulsed without a last window ack 3 cycles before");
        end

    readback: assert property (@(posedge clock) disable iff (!reset)
        rd_chk |=> (rd_data == rd_exp))
        else begin
            errors++;
            $display("** Error: o_rd_data = %h, expected %h", rd_data, rd_exp);
        end

    function automatic longint wrap48(input longint v);
        return (v <<< 16) >>> 16;
    endfunction

    // Q16.16 convolution, 48-bit sums, bias, clip, ReLU
    function automatic conv_pkg::data_t model_out(input int lane, input int col, input int nchan);
        longint acc;
        longint prod;
        acc = 0;
        for (int c = 0; c < nchan; c++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                prod = (longint'(pix[c][col][t]) * longint'(wt[lane][t])) >>> `FRAC_WIDTH;
                acc = wrap48(acc + wrap48(prod));
            end
        end
        acc = wrap48(acc + longint'(bias[lane]));
        if (acc > longint'(32'h7fff_ffff)) begin
            return 32'sh7fff_ffff;
        end else if (acc < 0) begin
            return '0;
        end
        return conv_pkg::data_t'(acc);
    endfunction

    function automatic conv_pkg::lane_data_t model_column(input int col, input int nchan);
        conv_pkg::lane_data_t v;
        for (int l = 0; l < `CONV_LANES; l++) begin
            v[l] = model_out(l, col, nchan);
        end
        return v;
    endfunction

    function automatic conv_pkg::data_t rand_small();
        return conv_pkg::data_t'($signed($urandom) >>> 12);
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic load_weights();
        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int s = 0; s <= `CONV_TAPS; s++) begin
                weight_load.valid = 1'b1;
                weight_load.lane  = conv_pkg::lane_t'(l);
                weight_load.slot  = 4'(s);
                weight_load.value = (s == `CONV_TAPS) ? bias[l] : wt[l][s];
                next_cycle();
            end
        end
        weight_load = '0;
    endtask

    // four-phase master that can hold req for extra cycles after ack
    task automatic send_window(input conv_pkg::window_t win, input logic last, input int hold);
        int waited;
        win_data = win;
        last_win = last;
        win_req  = 1'b1;
        seen_req = 1'b1;
        waited   = 0;
        while (!win_ack && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!win_ack) timeout_fail("no ack after req");
        repeat (hold) next_cycle();
        win_req = 1'b0;
        waited  = 0;
        while (win_ack && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (win_ack) timeout_fail("ack stuck high after req fell");
        last_win = 1'b0;
    endtask

    task automatic check_column(input int col, input conv_pkg::lane_data_t exp);
        rd_addr = conv_pkg::col_t'(col);
        rd_exp  = exp;
        rd_chk  = 1'b1;
        next_cycle();
        rd_chk = 1'b0;
        next_cycle();
    endtask

    task automatic run_frame(input int nchan, input int ncol, input int hold);
        conv_pkg::window_t win;
        int base;
        int waited;
        base = done_count;
        cfg.num_chans = conv_pkg::chan_t'(nchan);
        cfg.num_cols  = conv_pkg::col_t'(ncol);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        // channels first, then the next column
        for (int col = 0; col < ncol; col++) begin
            for (int ch = 0; ch < nchan; ch++) begin
                for (int t = 0; t < `CONV_TAPS; t++) begin
                    win[t] = pix[ch][col][t];
                end
                send_window(win, (col == ncol - 1) && (ch == nchan - 1), hold);
            end
        end
        waited = 0;
        while (done_count == base && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (done_count == base) timeout_fail("no done pulse for the frame");
        repeat (4) next_cycle();
        done_once: assert (done_count == base + 1) else begin
            errors++;
            $display("** Error: done_count = %h, expected %h", done_count, base + 1);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_base) tests_failed++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errors == test_base) ? "pass" : "fail", errors - test_base);
        test_base = errors;
    endtask

    initial begin
        void'($urandom(44511));
        reset = 1'b0;
        start = 1'b0;
        cfg = '0;
        win_req = 1'b0;
        win_data = '0;
        weight_load = '0;
        rd_addr = '0;
        last_win = 1'b0;
        seen_req = 1'b0;
        rd_chk = 1'b0;
        rd_exp = '0;
        for (int l = 0; l < `CONV_LANES; l++) begin
            bias[l] = '0;
            for (int t = 0; t < `CONV_TAPS; t++) begin
                wt[l][t] = '0;
            end
        end
        test_base = 0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1;

        repeat (6) next_cycle();
        end_test("idle after reset");

        // weights still zero from reset
        for (int t = 0; t < `CONV_TAPS; t++) pix[0][0][t] = rand_small();
        run_frame(1, 1, 3);
        check_column(0, model_column(0, 1));
        end_test("handshake");

        // lane 2 sums negative and must read zero
        for (int t = 0; t < `CONV_TAPS; t++) begin
            wt[0][t] = ONE;
            wt[1][t] = ONE >>> 1;
            wt[2][t] = -ONE;
            wt[3][t] = (t == 4) ? 2 * ONE : '0;
            for (int col = 0; col < 2; col++) begin
                pix[0][col][t] = conv_pkg::data_t'((t + 1) * 65536) >>> (2 * col);
            end
        end
        bias[0] = '0;
        bias[1] = ONE;
        bias[2] = '0;
        bias[3] = -(ONE >>> 1);
        load_weights();
        run_frame(1, 2, 0);
        for (int col = 0; col < 2; col++) check_column(col, model_column(col, 1));
        end_test("hand-picked weights");

        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int t = 0; t < `CONV_TAPS; t++) wt[l][t] = rand_small();
            bias[l] = rand_small();
        end
        for (int c = 0; c < 3; c++) begin
            for (int col = 0; col < 5; col++) begin
                for (int t = 0; t < `CONV_TAPS; t++) pix[c][col][t] = rand_small();
            end
        end
        load_weights();
        run_frame(3, 5, 0);
        for (int col = 0; col < 5; col++) check_column(col, model_column(col, 3));
        end_test("random frame");

        run_frame(2, 3, 1);
        for (int col = 0; col < 3; col++) check_column(col, model_column(col, 2));
        end_test("done once per frame");

        // 256.0 * 256.0 * 9 is far past the Q16.16 range
        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int t = 0; t < `CONV_TAPS; t++) wt[l][t] = 32'sh0100_0000;
            bias[l] = ONE;
        end
        for (int t = 0; t < `CONV_TAPS; t++) pix[0][0][t] = 32'sh0100_0000;
        load_weights();
        run_frame(1, 1, 0);
        check_column(0, {`CONV_LANES{32'h7fff_ffff}});
        end_test("saturation");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
conv_pkg.sv
window_receiver.sv
weight_bank.sv
mac_array.sv
channel_accumulator.sv
feature_memory.sv
conv_top.sv
tb_conv_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the conv engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_conv_top \
    --Mdir obj_dir \
    -o tb_conv_top
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/tb_conv_top)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$sim_output"; then
    exit 0
fi
echo "pass message not found"
exit 1
